/* include/givens_config.svh */
`ifndef GIVENS_CONFIG_SVH
`define GIVENS_CONFIG_SVH

// sample width at the element ports
`define GIVENS_DATA_W 18

// micro-rotations per engine, also the direction word width
`define GIVENS_ITER_NUM 14

// first shift of each later stage group
`define GIVENS_G1_FIRST 4
`define GIVENS_G2_FIRST 9

`define GIVENS_GROUP_NUM 3

// 1/K for 14 iterations, 0.6072 in Q14
`define GIVENS_GAIN 9949
`define GIVENS_GAIN_FRAC 14

`endif

/* verilog/givens_pkg.sv */
`default_nettype none

`include "givens_config.svh"

package givens_pkg;

    typedef logic signed [`GIVENS_DATA_W-1:0] sample_t;
    typedef logic signed [`GIVENS_DATA_W:0] wide_t; // one guard bit

    // bit set = positive-angle step
    typedef logic [`GIVENS_ITER_NUM-1:0] dir_t;
    typedef logic [`GIVENS_GROUP_NUM-1:0] dir_val_t;

    typedef enum logic {
        MODE_VECTOR = 1'b0,
        MODE_ROTATE = 1'b1
    } cordic_mode_e;

    typedef enum logic [1:0] {
        VEC_BOTH     = 2'd0,
        ROT_BOTH     = 2'd1,
        VEC_ROT_SWAP = 2'd2,
        ROT_SWAP     = 2'd3
    } pe_scheme_e;

endpackage

`default_nettype wire

/* verilog/cordic_iter_group.sv */
`timescale 1ns/1ns
`default_nettype none

module cordic_iter_group #(
    parameter int FIRST_SHIFT = 0,
    parameter int ITER_COUNT  = 4
) (
    input  wire givens_pkg::wide_t        x_i,
    input  wire givens_pkg::wide_t        y_i,
    input  wire givens_pkg::cordic_mode_e mode_i,
    input  wire logic [ITER_COUNT-1:0]    dir_i,
    output givens_pkg::wide_t             x_o,
    output givens_pkg::wide_t             y_o,
    output logic [ITER_COUNT-1:0]         dir_o
);

    import givens_pkg::*;

    localparam int MSB = $bits(wide_t) - 1;

    // unrolled shift-and-add chain, no registers inside a group
    always_comb begin
        wide_t x_c;
        wide_t y_c;
        wide_t x_sh;
        wide_t y_sh;
        logic  step;

        x_c   = x_i;
        y_c   = y_i;
        dir_o = '0;

        for (int k = 0; k < ITER_COUNT; k++) begin
            // vectoring pushes y toward zero
            if (mode_i == MODE_VECTOR) begin
                step = x_c[MSB] ^ y_c[MSB];
            end else begin
                step = dir_i[k];
            end

            x_sh = x_c >>> (FIRST_SHIFT + k);
            y_sh = y_c >>> (FIRST_SHIFT + k);

            if (step) begin
                x_c = x_c - y_sh;
                y_c = y_c + x_sh;
            end else begin
                x_c = x_c + y_sh;
                y_c = y_c - x_sh;
            end

            if (mode_i == MODE_VECTOR) begin
                dir_o[k] = step;
            end
        end

        x_o = x_c;
        y_o = y_c;
    end

endmodule

`default_nettype wire

/* verilog/cordic_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "givens_config.svh"

module cordic_engine (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire givens_pkg::cordic_mode_e mode_i,
    input  wire givens_pkg::sample_t      x_i,
    input  wire givens_pkg::sample_t      y_i,
    input  wire givens_pkg::dir_t         dir_i,
    output givens_pkg::sample_t           x_o,
    output givens_pkg::sample_t           y_o,
    output givens_pkg::dir_t              dir_o
);

    import givens_pkg::*;

    localparam int G0_CNT = `GIVENS_G1_FIRST;
    localparam int G1_CNT = `GIVENS_G2_FIRST - `GIVENS_G1_FIRST;
    localparam int G2_CNT = `GIVENS_ITER_NUM - `GIVENS_G2_FIRST;

    localparam int GAIN_W = `GIVENS_GAIN_FRAC + 2;
    localparam int PROD_W = $bits(wide_t) + GAIN_W;
    localparam logic signed [GAIN_W-1:0] GAIN_K = GAIN_W'(`GIVENS_GAIN);

    cordic_mode_e mode_g0;
    cordic_mode_e mode_q0;
    cordic_mode_e mode_q1;

    wide_t x_ext, y_ext;
    wide_t x_g0, y_g0, x_g1, y_g1, x_g2, y_g2;
    wide_t x_q0, y_q0, x_q1, y_q1, x_q2, y_q2;
    sample_t x_q3, y_q3;

    logic [G0_CNT-1:0] dir_g0;
    logic [G1_CNT-1:0] dir_g1;
    logic [G2_CNT-1:0] dir_g2;

    logic signed [PROD_W-1:0] x_prod, y_prod;

    assign mode_g0 = start_i ? mode_i : MODE_ROTATE; // idle slot rotates
    assign x_ext   = {x_i[`GIVENS_DATA_W-1], x_i};
    assign y_ext   = {y_i[`GIVENS_DATA_W-1], y_i};

    cordic_iter_group #(.FIRST_SHIFT(0), .ITER_COUNT(G0_CNT)) u_group0 (
        .x_i    (x_ext),
        .y_i    (y_ext),
        .mode_i (mode_g0),
        .dir_i  (dir_i[G0_CNT-1:0]),
        .x_o    (x_g0),
        .y_o    (y_g0),
        .dir_o  (dir_g0)
    );

    cordic_iter_group #(.FIRST_SHIFT(`GIVENS_G1_FIRST), .ITER_COUNT(G1_CNT)) u_group1 (
        .x_i    (x_q0),
        .y_i    (y_q0),
        .mode_i (mode_q0),
        .dir_i  (dir_i[`GIVENS_G2_FIRST-1:`GIVENS_G1_FIRST]),
        .x_o    (x_g1),
        .y_o    (y_g1),
        .dir_o  (dir_g1)
    );

    cordic_iter_group #(.FIRST_SHIFT(`GIVENS_G2_FIRST), .ITER_COUNT(G2_CNT)) u_group2 (
        .x_i    (x_q1),
        .y_i    (y_q1),
        .mode_i (mode_q1),
        .dir_i  (dir_i[`GIVENS_ITER_NUM-1:`GIVENS_G2_FIRST]),
        .x_o    (x_g2),
        .y_o    (y_g2),
        .dir_o  (dir_g2)
    );

    // each slice leaves in its own group's cycle
    assign dir_o = {dir_g2, dir_g1, dir_g0};

    // gain correction
    assign x_prod = x_q2 * GAIN_K;
    assign y_prod = y_q2 * GAIN_K;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q0 <= MODE_ROTATE;
            mode_q1 <= MODE_ROTATE;
            x_q0    <= '0;
            y_q0    <= '0;
            x_q1    <= '0;
            y_q1    <= '0;
            x_q2    <= '0;
            y_q2    <= '0;
            x_q3    <= '0;
            y_q3    <= '0;
        end else begin
            mode_q0 <= mode_g0;
            mode_q1 <= mode_q0;
            x_q0    <= x_g0;
            y_q0    <= y_g0;
            x_q1    <= x_g1;
            y_q1    <= y_g1;
            x_q2    <= x_g2;
            y_q2    <= y_g2;
            x_q3    <= x_prod[`GIVENS_GAIN_FRAC +: `GIVENS_DATA_W]; // drop guard bit
            y_q3    <= y_prod[`GIVENS_GAIN_FRAC +: `GIVENS_DATA_W];
        end
    end

    assign x_o = x_q3;
    assign y_o = y_q3;

endmodule

`default_nettype wire

/* verilog/givens_scheme_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "givens_config.svh"

module givens_scheme_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [1:0]               valid_i,
    input  wire givens_pkg::pe_scheme_e   scheme_i,
    output givens_pkg::cordic_mode_e      mode0_o,
    output givens_pkg::cordic_mode_e      mode1_o,
    output logic [`GIVENS_GROUP_NUM:0]    swap_o,
    output givens_pkg::dir_val_t          dir_val0_o,
    output givens_pkg::dir_val_t          dir_val1_o
);

    import givens_pkg::*;

    localparam int STAGES = `GIVENS_GROUP_NUM + 1; // groups plus gain stage

    logic              swap_c;
    logic [STAGES-2:0] swap_q;
    logic              vec0_c, vec1_c;
    logic [`GIVENS_GROUP_NUM-2:0] vec0_q, vec1_q;

    always_comb begin
        case (scheme_i)
            VEC_BOTH: begin
                swap_c  = 1'b0;
                mode0_o = MODE_VECTOR;
                mode1_o = MODE_VECTOR;
            end
            ROT_BOTH: begin
                swap_c  = 1'b0;
                mode0_o = MODE_ROTATE;
                mode1_o = MODE_ROTATE;
            end
            VEC_ROT_SWAP: begin
                swap_c  = 1'b1;
                mode0_o = MODE_VECTOR;
                mode1_o = MODE_ROTATE;
            end
            default: begin
                swap_c  = 1'b1;
                mode0_o = MODE_ROTATE;
                mode1_o = MODE_ROTATE;
            end
        endcase
    end

    // only a started vectoring sample produces directions
    assign vec0_c = valid_i[0] & (mode0_o == MODE_VECTOR);
    assign vec1_c = valid_i[1] & (mode1_o == MODE_VECTOR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_q <= '0;
            vec0_q <= '0;
            vec1_q <= '0;
        end else begin
            swap_q <= {swap_q[STAGES-3:0], swap_c};
            vec0_q <= {vec0_q[`GIVENS_GROUP_NUM-3:0], vec0_c};
            vec1_q <= {vec1_q[`GIVENS_GROUP_NUM-3:0], vec1_c};
        end
    end

    assign swap_o     = {swap_q, swap_c};
    assign dir_val0_o = {vec0_q, vec0_c};

    // swapped slices report engine 0
    assign dir_val1_o = ({vec1_q, vec1_c} & ~swap_o[`GIVENS_GROUP_NUM-1:0])
                      | ({vec0_q, vec0_c} &  swap_o[`GIVENS_GROUP_NUM-1:0]);

endmodule

`default_nettype wire

/* verilog/givens_pe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "givens_config.svh"

module givens_pe (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [1:0]             valid_i,
    input  wire givens_pkg::pe_scheme_e scheme_i,
    input  wire givens_pkg::sample_t    x0_i,
    input  wire givens_pkg::sample_t    y0_i,
    input  wire givens_pkg::sample_t    x1_i,
    input  wire givens_pkg::sample_t    y1_i,
    input  wire givens_pkg::dir_t       dir0_i,
    input  wire givens_pkg::dir_t       dir1_i,
    output givens_pkg::sample_t         x0_o,
    output givens_pkg::sample_t         y0_o,
    output givens_pkg::sample_t         x1_o,
    output givens_pkg::sample_t         y1_o,
    output givens_pkg::dir_t            dir0_o,
    output givens_pkg::dir_t            dir1_o,
    output givens_pkg::dir_val_t        dir_val0_o,
    output givens_pkg::dir_val_t        dir_val1_o
);

    import givens_pkg::*;

    localparam int G0_CNT = `GIVENS_G1_FIRST;
    localparam int G1_CNT = `GIVENS_G2_FIRST - `GIVENS_G1_FIRST;
    localparam int G2_CNT = `GIVENS_ITER_NUM - `GIVENS_G2_FIRST;

    cordic_mode_e mode0, mode1;
    logic [`GIVENS_GROUP_NUM:0] swap;
    logic swap_out_q;

    sample_t e0_y_in, e1_x_in;
    sample_t e0_y_out, e1_x_out;
    dir_t    e1_dir;
    dir_t    dir_sel;

    givens_scheme_ctrl u_scheme_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .scheme_i   (scheme_i),
        .mode0_o    (mode0),
        .mode1_o    (mode1),
        .swap_o     (swap),
        .dir_val0_o (dir_val0_o),
        .dir_val1_o (dir_val1_o)
    );

    // inner operands cross over when swapped
    assign e0_y_in = swap[0] ? x1_i : y0_i;
    assign e1_x_in = swap[0] ? y0_i : x1_i;

    cordic_engine engine0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (valid_i[0]),
        .mode_i  (mode0),
        .x_i     (x0_i),
        .y_i     (e0_y_in),
        .dir_i   (dir0_i),
        .x_o     (x0_o),
        .y_o     (e0_y_out),
        .dir_o   (dir0_o)
    );

    cordic_engine engine1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (valid_i[1]),
        .mode_i  (mode1),
        .x_i     (e1_x_in),
        .y_i     (y1_i),
        .dir_i   (dir1_i),
        .x_o     (e1_x_out),
        .y_o     (y1_o),
        .dir_o   (e1_dir)
    );

    // gain stage output lags the stage-3 flag by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_out_q <= 1'b0;
        end else begin
            swap_out_q <= swap[3];
        end
    end

    assign y0_o = swap_out_q ? e1_x_out : e0_y_out;
    assign x1_o = swap_out_q ? e0_y_out : e1_x_out;

    // per-slice pick of engine 0 directions
    assign dir_sel = {{G2_CNT{swap[2]}}, {G1_CNT{swap[1]}}, {G0_CNT{swap[0]}}};
    assign dir1_o  = (e1_dir & ~dir_sel) | (dir0_o & dir_sel);

endmodule

`default_nettype wire

/* verif/givens_ref_model.sv */
`default_nettype none

`include "givens_config.svh"

package givens_ref_model;

    import givens_pkg::*;

    typedef struct packed {
        sample_t x;
        sample_t y;
        dir_t    dir;
    } cordic_res_t;

    typedef struct packed {
        cordic_mode_e mode0;
        cordic_mode_e mode1;
        logic         swap;
    } scheme_res_t;

    // fixed-point CORDIC, 19-bit working width, wraps like hardware
    function automatic cordic_res_t cordic_ref(cordic_mode_e mode, sample_t x_in,
                                               sample_t y_in, dir_t dir_in);
        cordic_res_t res;
        logic signed [`GIVENS_DATA_W:0] x, y, dx, dy;
        logic signed [`GIVENS_DATA_W+`GIVENS_GAIN_FRAC+2:0] px, py;
        logic signed [`GIVENS_GAIN_FRAC+1:0] k;
        logic pos;

        res.dir = '0;
        x = x_in;
        y = y_in;
        k = `GIVENS_GAIN;
        for (int i = 0; i < `GIVENS_ITER_NUM; i++) begin
            if (mode == MODE_VECTOR) begin
                pos = (x < 0) != (y < 0); // rotate y back toward the axis
                res.dir[i] = pos;
            end else begin
                pos = dir_in[i];
            end
            dx = y >>> i;
            dy = x >>> i;
            if (pos) begin
                x = x - dx;
                y = y + dy;
            end else begin
                x = x + dx;
                y = y - dy;
            end
        end
        px = x * k;
        py = y * k;
        res.x = px[`GIVENS_GAIN_FRAC +: `GIVENS_DATA_W];
        res.y = py[`GIVENS_GAIN_FRAC +: `GIVENS_DATA_W];
        return res;
    endfunction

    function automatic scheme_res_t scheme_ref(pe_scheme_e s);
        scheme_res_t r;

        r.swap  = (s == VEC_ROT_SWAP) || (s == ROT_SWAP);
        r.mode0 = (s == VEC_BOTH || s == VEC_ROT_SWAP) ? MODE_VECTOR : MODE_ROTATE;
        r.mode1 = (s == VEC_BOTH) ? MODE_VECTOR : MODE_ROTATE;
        return r;
    endfunction

endpackage

`default_nettype wire

/* verif/givens_pe_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "givens_config.svh"

module givens_pe_tb;

    import givens_pkg::*;
    import givens_ref_model::*;

    localparam int OFS = 8;
    localparam int N_TEST = 200;
    localparam int TOTAL = 6 + 4 * (N_TEST + 6) + 100; // mix test runs longer
    localparam int MAXC = OFS + TOTAL + 16;

    logic clk, rst_n;
    logic [1:0] valid_i;
    pe_scheme_e scheme_i;
    sample_t x0_i, y0_i, x1_i, y1_i, x0_o, y0_o, x1_o, y1_o;
    dir_t dir0_i, dir1_i, dir0_o, dir1_o;
    dir_val_t dir_val0_o, dir_val1_o;

    sample_t e0x_h[MAXC], e0y_h[MAXC], e1x_h[MAXC], e1y_h[MAXC];
    dir_t d0_h[MAXC], d1_h[MAXC], rd0_h[MAXC], rd1_h[MAXC];
    logic sw_h[MAXC], v0_h[MAXC], v1_h[MAXC];

    int cyc = OFS;
    int errors = 0;
    int checks = 0;
    logic near_zero = 1'b0;
    logic [31:0] lfsr = 32'hcf75;

    givens_pe givens_pe_i (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .scheme_i(scheme_i),
        .x0_i(x0_i), .y0_i(y0_i), .x1_i(x1_i), .y1_i(y1_i),
        .dir0_i(dir0_i), .dir1_i(dir1_i),
        .x0_o(x0_o), .y0_o(y0_o), .x1_o(x1_o), .y1_o(y1_o),
        .dir0_o(dir0_o), .dir1_o(dir1_o), .dir_val0_o(dir_val0_o), .dir_val1_o(dir_val1_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic sample_t rand_signed(int w);
        logic signed [31:0] r;
        r = $signed(rand_bits(w) << (32 - w)) >>> (32 - w);
        return sample_t'(r);
    endfunction

    function automatic dir_t slice_mask(int g);
        int lo = (g == 0) ? 0 : (g == 1) ? `GIVENS_G1_FIRST : `GIVENS_G2_FIRST;
        int hi = (g == 0) ? `GIVENS_G1_FIRST : (g == 1) ? `GIVENS_G2_FIRST : `GIVENS_ITER_NUM;
        dir_t m = '0;
        for (int i = lo; i < hi; i++) m[i] = 1'b1;
        return m;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called right after a rising edge
    task automatic drive_cycle(input pe_scheme_e s, input logic [1:0] v, input sample_t a0,
                               input sample_t b0, input sample_t a1, input sample_t b1,
                               input dir_t r0, input dir_t r1);
        scheme_res_t sc;
        cordic_res_t res0, res1;
        sc = scheme_ref(s);
        res0 = cordic_ref(v[0] ? sc.mode0 : MODE_ROTATE, a0, sc.swap ? a1 : b0, r0);
        res1 = cordic_ref(v[1] ? sc.mode1 : MODE_ROTATE, sc.swap ? b0 : a1, b1, r1);
        {e0x_h[cyc], e0y_h[cyc], d0_h[cyc]} = res0;
        {e1x_h[cyc], e1y_h[cyc], d1_h[cyc]} = res1;
        rd0_h[cyc] = r0;
        rd1_h[cyc] = r1;
        sw_h[cyc] = sc.swap;
        v0_h[cyc] = v[0] && sc.mode0 == MODE_VECTOR;
        v1_h[cyc] = v[1] && sc.mode1 == MODE_VECTOR;
        valid_i <= v;
        scheme_i <= s;
        {x0_i, y0_i, x1_i, y1_i} <= {a0, b0, a1, b1};
        // rotation words arrive one slice per cycle
        dir0_i <= (r0 & slice_mask(0)) | (rd0_h[cyc-1] & slice_mask(1))
                | (rd0_h[cyc-2] & slice_mask(2));
        dir1_i <= (r1 & slice_mask(0)) | (rd1_h[cyc-1] & slice_mask(1))
                | (rd1_h[cyc-2] & slice_mask(2));
    endtask

    task automatic check_cycle();
        int k = cyc - 4;
        logic sw_k = sw_h[cyc-4]; // unswap travels with the data
        dir_val_t dv0, dv1;
        for (int g = 0; g < `GIVENS_GROUP_NUM; g++) begin
            dv0[g] = v0_h[cyc-g];
            dv1[g] = sw_h[cyc-g] ? v0_h[cyc-g] : v1_h[cyc-g];
            if (dv0[g])
                check_val("dir0_o", 32'(dir0_o & slice_mask(g)), 32'(d0_h[cyc-g] & slice_mask(g)));
            if (dv1[g])
                check_val("dir1_o", 32'(dir1_o & slice_mask(g)),
                          32'((sw_h[cyc-g] ? d0_h[cyc-g] : d1_h[cyc-g]) & slice_mask(g)));
        end
        check_val("dir_val0_o", 32'(dir_val0_o), 32'(dv0));
        check_val("dir_val1_o", 32'(dir_val1_o), 32'(dv1));
        check_val("x0_o", 32'(x0_o), 32'(e0x_h[k]));
        check_val("y0_o", 32'(y0_o), 32'(sw_k ? e1x_h[k] : e0y_h[k]));
        check_val("x1_o", 32'(x1_o), 32'(sw_k ? e0y_h[k] : e1x_h[k]));
        check_val("y1_o", 32'(y1_o), 32'(e1y_h[k]));
        if (near_zero && ((v0_h[k] && (y0_o > 32 || y0_o < -32))
                || (v1_h[k] && (y1_o > 32 || y1_o < -32)))) begin
            errors++;
            $display("[FAIL] t=%0t vectoring left y far from zero", $time);
        end
    endtask

    // kind 0 vectoring, 1 rotation, 2 swapped vector-rotate, 3 mix, 4 idle
    task automatic run_test(input string name, input int kind, input int n);
        int err0 = errors;
        logic [31:0] r;
        pe_scheme_e s;
        for (int i = 0; i < n + 6; i++) begin
            r = rand_bits(4);
            s = (kind == 1) ? ROT_BOTH : (kind == 2) ? VEC_ROT_SWAP : VEC_BOTH;
            if (kind == 3) s = pe_scheme_e'(r[3:2]);
            @(posedge clk);
            if (i < n && kind != 4)
                drive_cycle(s, r[1:0], (kind == 3) ? rand_signed(17) : sample_t'(rand_bits(15)),
                            rand_signed(16), rand_signed(16), rand_signed(16),
                            dir_t'(rand_bits(14)), dir_t'(rand_bits(14)));
            else
                drive_cycle(s, 2'b00, '0, '0, '0, '0, '0, '0);
            @(negedge clk);
            check_cycle();
            if (kind == 4)
                check_val("all outputs", 32'({x0_o, y0_o, x1_o, y1_o, dir_val0_o, dir_val1_o}
                          != '0), 32'(0));
            cyc++;
        end
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    initial begin
        #(TOTAL * 8 + 400);
        $display("timeout: the tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        for (int i = 0; i < MAXC; i++) begin
            {e0x_h[i], e0y_h[i], e1x_h[i], e1y_h[i]} = '0;
            {d0_h[i], d1_h[i], rd0_h[i], rd1_h[i]} = '0;
            {sw_h[i], v0_h[i], v1_h[i]} = '0;
        end
        clk = 1'b0;
        rst_n = 1'b0;
        valid_i = 2'b00;
        scheme_i = VEC_BOTH;
        {x0_i, y0_i, x1_i, y1_i} = '0;
        {dir0_i, dir1_i} = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        run_test("reset", 4, 0);
        near_zero = 1'b1;
        run_test("vec_both", 0, N_TEST);
        near_zero = 1'b0;
        run_test("rot_both", 1, N_TEST);
        run_test("vec_rot_swap", 2, N_TEST);
        run_test("mix", 3, N_TEST + 100);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* givens_pe.f */
+incdir+include
verilog/givens_pkg.sv
verilog/cordic_iter_group.sv
verilog/cordic_engine.sv
verilog/givens_scheme_ctrl.sv
verilog/givens_pe.sv
verif/givens_ref_model.sv
verif/givens_pe_tb.sv

/* Makefile */
sim:
	verilator --binary --timing -Wno-fatal -f givens_pe.f --top-module givens_pe_tb -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
